// File: Makefile
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_datapath -f datapath.f -o vsim
	./obj_dir/vsim | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: datapath.f
verilog/rv32i_pkg.sv
verilog/decode_ctrl.sv
verilog/regfile.sv
verilog/execute_stage.sv
verilog/mem_align.sv
verilog/datapath.sv
sim/datapath_assertions.sv
sim/tb_datapath.sv

// File: sim/datapath_assertions.sv
`timescale 1ns/1ps

module datapath_assertions (
  input logic             clk,
  input logic             rst_n,
  input rv32i_pkg::word_t icache_address,
  input logic             icache_read,
  input logic             icache_resp,
  input rv32i_pkg::word_t dcache_address,
  input logic             dcache_read,
  input logic             dcache_write,
  input rv32i_pkg::word_t dcache_wdata,
  input rv32i_pkg::mbe_t  dcache_mbe,
  input logic             dcache_resp
);

  // Data request held until its response
  a_dcache_stable: assert property (@(posedge clk) disable iff (!rst_n)
    ((dcache_read || dcache_write) && !dcache_resp) |=>
      ($stable(dcache_read) && $stable(dcache_write) && $stable(dcache_address) &&
       $stable(dcache_wdata) && $stable(dcache_mbe)))
    else $error("dcache request changed before dcache_resp");

  // Fetch address frozen while the fetch waits
  a_icache_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (icache_read && !icache_resp) |=> (icache_read && $stable(icache_address)))
    else $error("icache request changed before icache_resp");

  a_rw_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(dcache_read && dcache_write))
    else $error("dcache_read and dcache_write both high");

  a_addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    (dcache_read || dcache_write) |-> (dcache_address[1:0] == 2'b00))
    else $error("dcache_address not word aligned");

  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |-> (!dcache_read && !dcache_write && !icache_read))
    else $error("strobe high during reset");

endmodule

bind datapath datapath_assertions u_datapath_assertions (
  .clk(clk), .rst_n(rst_n),
  .icache_address(icache_address), .icache_read(icache_read), .icache_resp(icache_resp),
  .dcache_address(dcache_address), .dcache_read(dcache_read), .dcache_write(dcache_write),
  .dcache_wdata(dcache_wdata), .dcache_mbe(dcache_mbe), .dcache_resp(dcache_resp)
);

// File: sim/tb_datapath.sv
`timescale 1ns/1ps

module tb_datapath;

  localparam int NUM_RANDOM = 200;
  localparam int NUM_INSTR  = NUM_RANDOM + 31;
  localparam int CYCLE_LIMIT = 16 + NUM_INSTR * 2 * 4 + 100;

  logic             clk;
  logic             rst_n;
  rv32i_pkg::word_t icache_address;
  logic             icache_read;
  rv32i_pkg::word_t icache_rdata;
  logic             icache_resp;
  rv32i_pkg::word_t dcache_address;
  logic             dcache_read;
  logic             dcache_write;
  rv32i_pkg::word_t dcache_wdata;
  rv32i_pkg::mbe_t  dcache_mbe;
  rv32i_pkg::word_t dcache_rdata;
  logic             dcache_resp;

  logic [31:0]      lcg_state;
  rv32i_pkg::word_t prog [0:255];
  rv32i_pkg::word_t dmem [0:63];
  rv32i_pkg::word_t model_mem [0:63];
  rv32i_pkg::word_t model_reg [0:31];
  rv32i_pkg::word_t exp_addr [$];
  rv32i_pkg::word_t exp_wdata [$];
  rv32i_pkg::mbe_t  exp_mbe [$];
  rv32i_pkg::word_t exp_load_addr [$];
  logic [1:0]       i_wait;
  logic [1:0]       d_wait;
  int               exp_total;
  int               seen_stores;
  int               mismatch_count;
  int               other_count;
  int               cycle;

  datapath dut0 (
    .clk(clk), .rst_n(rst_n),
    .icache_address(icache_address), .icache_read(icache_read),
    .icache_rdata(icache_rdata), .icache_resp(icache_resp),
    .dcache_address(dcache_address), .dcache_read(dcache_read),
    .dcache_write(dcache_write), .dcache_wdata(dcache_wdata), .dcache_mbe(dcache_mbe),
    .dcache_rdata(dcache_rdata), .dcache_resp(dcache_resp)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Reference ALU built from the ISA definition
  function automatic rv32i_pkg::word_t ref_alu(logic [2:0] f3, logic alt,
                                               rv32i_pkg::word_t a, rv32i_pkg::word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic rv32i_pkg::word_t random_instr();
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    r   = lcg_next();
    rd  = {2'b00, r[5:3]};
    rs1 = {2'b00, r[8:6]};
    rs2 = {2'b00, r[11:9]};
    f3  = r[14:12];
    imm = r[26:15];
    case (r[2:0])
      3'd1, 3'd6: begin
        // Shift immediates keep the upper bits legal
        if (f3 == 3'd1) imm = {7'h00, r[19:15]};
        if (f3 == 3'd5) imm = {r[27] ? 7'h20 : 7'h00, r[19:15]};
        return {imm, rs1, f3, rd, rv32i_pkg::OP_IMM};
      end
      3'd2: return {r[31:12], rd, rv32i_pkg::OP_LUI};
      3'd3, 3'd7: begin
        case (r[14:12])
          3'd0, 3'd5: f3 = rv32i_pkg::F3_B;
          3'd1, 3'd6: f3 = rv32i_pkg::F3_H;
          3'd2:       f3 = rv32i_pkg::F3_W;
          3'd3, 3'd7: f3 = rv32i_pkg::F3_BU;
          default:    f3 = rv32i_pkg::F3_HU;
        endcase
        return {imm, rs1, f3, rd, rv32i_pkg::OP_LOAD};
      end
      3'd4: begin
        f3 = (r[13:12] == 2'd0) ? rv32i_pkg::F3_B :
             (r[13:12] == 2'd1) ? rv32i_pkg::F3_H : rv32i_pkg::F3_W;
        return {imm[11:5], rs2, rs1, f3, imm[4:0], rv32i_pkg::OP_STORE};
      end
      default: begin
        return {(r[27] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                rs2, rs1, f3, rd, rv32i_pkg::OP_REG};
      end
    endcase
  endfunction

  // In-order ISA model, one instruction at a time
  task automatic model_step(rv32i_pkg::word_t instr);
    rv32i_pkg::word_t a;
    rv32i_pkg::word_t b;
    rv32i_pkg::word_t i_imm;
    rv32i_pkg::word_t s_imm;
    rv32i_pkg::word_t addr;
    rv32i_pkg::word_t raw;
    rv32i_pkg::word_t wd;
    logic [7:0]       mask;
    logic [7:0]       bv;
    logic [15:0]      hv;
    logic [1:0]       off;
    logic [2:0]       f3;
    logic [4:0]       rd;
    a     = model_reg[instr[19:15]];
    b     = model_reg[instr[24:20]];
    f3    = instr[14:12];
    rd    = instr[11:7];
    i_imm = {{20{instr[31]}}, instr[31:20]};
    s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    case (instr[6:0])
      rv32i_pkg::OP_REG: model_reg[rd] = ref_alu(f3, instr[30], a, b);
      rv32i_pkg::OP_IMM: model_reg[rd] = ref_alu(f3, instr[30] && (f3 == 3'd5), a, i_imm);
      rv32i_pkg::OP_LUI: model_reg[rd] = {instr[31:12], 12'h000};
      rv32i_pkg::OP_LOAD: begin
        addr = a + i_imm;
        off  = addr[1:0];
        raw  = model_mem[addr[7:2]];
        bv   = raw[8*off +: 8];
        hv   = off[1] ? raw[31:16] : raw[15:0];
        case (f3)
          rv32i_pkg::F3_B:  model_reg[rd] = {{24{bv[7]}}, bv};
          rv32i_pkg::F3_BU: model_reg[rd] = {24'h0, bv};
          rv32i_pkg::F3_H:  model_reg[rd] = off[0] ? 32'h0 : {{16{hv[15]}}, hv};
          rv32i_pkg::F3_HU: model_reg[rd] = off[0] ? 32'h0 : {16'h0, hv};
          default:          model_reg[rd] = raw;
        endcase
        exp_load_addr.push_back({addr[31:2], 2'b00});
      end
      rv32i_pkg::OP_STORE: begin
        addr = a + s_imm;
        off  = addr[1:0];
        wd   = (f3 == rv32i_pkg::F3_W) ? b : b << (8 * off);
        mask = (f3 == rv32i_pkg::F3_W) ? 8'h0f :
               (f3 == rv32i_pkg::F3_H) ? (8'h03 << off) : (8'h01 << off);
        for (int k = 0; k < 4; k++) begin
          if (mask[k]) model_mem[addr[7:2]][8*k +: 8] = wd[8*k +: 8];
        end
        exp_addr.push_back({addr[31:2], 2'b00});
        exp_wdata.push_back(wd);
        exp_mbe.push_back(mask[3:0]);
      end
      default: begin
      end
    endcase
    model_reg[0] = '0;
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Memories answer through a random wait per access
  assign icache_resp  = icache_read && (i_wait == 2'd0);
  assign dcache_resp  = (dcache_read || dcache_write) && (d_wait == 2'd0);
  assign icache_rdata = (icache_address[31:2] < NUM_INSTR) ? prog[icache_address[9:2]] :
                        rv32i_pkg::NOP_INSTR;
  assign dcache_rdata = dmem[dcache_address[7:2]];

  always @(posedge clk) begin
    if (icache_read && icache_resp) begin
      i_wait <= 2'(lcg_next() >> 30);
    end else if (icache_read && i_wait != 2'd0) begin
      i_wait <= i_wait - 2'd1;
    end
    if (dcache_resp) begin
      d_wait <= 2'(lcg_next() >> 30);
    end else if ((dcache_read || dcache_write) && d_wait != 2'd0) begin
      d_wait <= d_wait - 2'd1;
    end
    if (dcache_write && dcache_resp) begin
      for (int k = 0; k < 4; k++) begin
        if (dcache_mbe[k]) dmem[dcache_address[7:2]][8*k +: 8] <= dcache_wdata[8*k +: 8];
      end
    end
  end

  // Fetch strobe and data access events against the model sequences
  always @(posedge clk) begin
    if (!rst_n) begin
      if (dcache_read || dcache_write) begin
        $display("Data strobe raised during reset");
        other_count++;
      end
    end else begin
      if (!icache_read) begin
        $display("MISMATCH icache_read got %h exp %h", icache_read, 1'b1);
        mismatch_count++;
      end
      if (dcache_read && dcache_resp) begin
        if (exp_load_addr.size() == 0) begin
          $display("Unexpected extra load from %h", dcache_address);
          other_count++;
        end else begin
          if (dcache_address != exp_load_addr[0]) begin
            $display("MISMATCH dcache_address got %h exp %h", dcache_address,
                     exp_load_addr[0]);
            mismatch_count++;
          end
          void'(exp_load_addr.pop_front());
        end
      end
      if (dcache_write && dcache_resp) begin
        seen_stores++;
        if (exp_addr.size() == 0) begin
          $display("Unexpected extra store to %h", dcache_address);
          other_count++;
        end else begin
          if (dcache_address != exp_addr[0]) begin
            $display("MISMATCH dcache_address got %h exp %h", dcache_address, exp_addr[0]);
            mismatch_count++;
          end
          if (dcache_wdata != exp_wdata[0]) begin
            $display("MISMATCH dcache_wdata got %h exp %h", dcache_wdata, exp_wdata[0]);
            mismatch_count++;
          end
          if (dcache_mbe != exp_mbe[0]) begin
            $display("MISMATCH dcache_mbe got %h exp %h", dcache_mbe, exp_mbe[0]);
            mismatch_count++;
          end
          void'(exp_addr.pop_front());
          void'(exp_wdata.pop_front());
          void'(exp_mbe.pop_front());
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle++;
    if (cycle >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles with %0d of %0d stores seen",
               cycle, seen_stores, exp_total);
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    lcg_state      = 32'hf000_b103;
    rst_n          = 1'b0;
    i_wait         = 2'd0;
    d_wait         = 2'd0;
    seen_stores    = 0;
    mismatch_count = 0;
    other_count    = 0;
    cycle          = 0;
    for (int i = 0; i < 256; i++) prog[i] = rv32i_pkg::NOP_INSTR;
    for (int i = 0; i < NUM_RANDOM; i++) prog[i] = random_instr();
    // Dump x1 to x31 with SW to fixed addresses
    for (int i = 1; i < 32; i++) begin
      prog[NUM_RANDOM + i - 1] = {7'h20, 5'(i), 5'd0, rv32i_pkg::F3_W, 5'(4 * i),
                                  rv32i_pkg::OP_STORE};
    end
    for (int i = 0; i < 64; i++) begin
      dmem[i]      = lcg_next();
      model_mem[i] = dmem[i];
    end
    for (int i = 0; i < 32; i++) model_reg[i] = '0;
    for (int i = 0; i < NUM_INSTR; i++) model_step(prog[i]);
    exp_total = exp_addr.size();
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    #1;
    if (icache_address != rv32i_pkg::RESET_PC) begin
      $display("MISMATCH icache_address got %h exp %h", icache_address, rv32i_pkg::RESET_PC);
      mismatch_count++;
    end
    if (dcache_read || dcache_write) begin
      $display("Data strobe high right after reset");
      other_count++;
    end
    // Run until the fetch address leaves the program
    while (icache_address[31:2] < NUM_INSTR) @(posedge clk);
    // Drain the pipe and let the NOP tail run to catch stray accesses
    repeat (20) @(posedge clk);
    if (exp_addr.size() != 0 || exp_load_addr.size() != 0) begin
      $display("Missing %0d expected stores and %0d expected loads",
               exp_addr.size(), exp_load_addr.size());
      other_count++;
    end
    $display("Stores %0d, mismatches %0d, other errors %0d",
             seen_stores, mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/datapath.sv
`timescale 1ns/1ps

module datapath (
  input  logic             clk,
  input  logic             rst_n,
  // Instruction side
  output rv32i_pkg::word_t icache_address,
  output logic             icache_read,
  input  rv32i_pkg::word_t icache_rdata,
  input  logic             icache_resp,
  // Data side
  output rv32i_pkg::word_t dcache_address,
  output logic             dcache_read,
  output logic             dcache_write,
  output rv32i_pkg::word_t dcache_wdata,
  output rv32i_pkg::mbe_t  dcache_mbe,
  input  rv32i_pkg::word_t dcache_rdata,
  input  logic             dcache_resp
);

  logic                icache_stall;
  logic                dcache_stall;
  logic                stall;
  logic                advance;
  rv32i_pkg::word_t    pc;
  rv32i_pkg::word_t    ifid_instr;
  // Decode outputs
  rv32i_pkg::reg_idx_t id_rs1, id_rs2, id_rd;
  rv32i_pkg::word_t    id_imm, rf_rdata_a, rf_rdata_b;
  rv32i_pkg::alu_op_t  id_alu_op;
  rv32i_pkg::funct3_t  id_funct3;
  logic                id_src2_imm, id_reg_write, id_mem_read, id_mem_write;
  // ID/EX
  rv32i_pkg::reg_idx_t idex_rs1, idex_rs2, idex_rd;
  rv32i_pkg::word_t    idex_imm, idex_rs1_val, idex_rs2_val;
  rv32i_pkg::alu_op_t  idex_alu_op;
  rv32i_pkg::funct3_t  idex_funct3;
  logic                idex_src2_imm, idex_reg_write, idex_mem_read, idex_mem_write;
  rv32i_pkg::word_t    ex_alu_result, ex_store_data;
  // EX/MEM
  rv32i_pkg::reg_idx_t exmem_rd, exmem_rs2;
  rv32i_pkg::word_t    exmem_alu, exmem_store_data;
  rv32i_pkg::funct3_t  exmem_funct3;
  logic                exmem_reg_write, exmem_mem_read, exmem_mem_write;
  rv32i_pkg::word_t    mem_store_src, mem_load_raw, mem_load_value, mem_result;
  logic                dcache_done;
  rv32i_pkg::word_t    held_rdata;
  // MEM/WB
  rv32i_pkg::reg_idx_t memwb_rd;
  logic                memwb_reg_write;
  rv32i_pkg::word_t    memwb_value;

  // Global freeze while either side waits
  assign icache_stall = icache_read & ~icache_resp;
  assign dcache_stall = (dcache_read | dcache_write) & ~dcache_resp;
  assign stall        = icache_stall | dcache_stall;
  assign advance      = ~stall;

  assign icache_address = pc;
  assign icache_read    = rst_n;

  decode_ctrl u_decode (
    .instr(ifid_instr), .rs1(id_rs1), .rs2(id_rs2), .rd(id_rd), .imm(id_imm),
    .alu_op(id_alu_op), .src2_imm(id_src2_imm), .reg_write(id_reg_write),
    .mem_read(id_mem_read), .mem_write(id_mem_write), .funct3(id_funct3)
  );

  regfile u_regfile (
    .clk(clk), .rst_n(rst_n), .we(memwb_reg_write), .waddr(memwb_rd),
    .wdata(memwb_value), .raddr_a(id_rs1), .raddr_b(id_rs2),
    .rdata_a(rf_rdata_a), .rdata_b(rf_rdata_b)
  );

  execute_stage u_execute (
    .rs1(idex_rs1), .rs2(idex_rs2), .rs1_val(idex_rs1_val), .rs2_val(idex_rs2_val),
    .imm(idex_imm), .alu_op(idex_alu_op), .src2_imm(idex_src2_imm),
    .mem_rd(exmem_rd), .mem_reg_write(exmem_reg_write), .mem_is_load(exmem_mem_read),
    .mem_alu(exmem_alu), .mem_rdata(mem_load_value),
    .wb_rd(memwb_rd), .wb_reg_write(memwb_reg_write), .wb_value(memwb_value),
    .alu_result(ex_alu_result), .store_data(ex_store_data)
  );

  // Access finished but an instruction fetch still holds the pipe
  assign dcache_read    = exmem_mem_read & ~dcache_done;
  assign dcache_write   = exmem_mem_write & ~dcache_done;
  assign dcache_address = {exmem_alu[31:2], 2'b00};
  assign mem_load_raw   = dcache_done ? held_rdata : dcache_rdata;

  // Store data may still be produced by the writeback instruction
  assign mem_store_src = (memwb_reg_write && (memwb_rd != '0) && (memwb_rd == exmem_rs2)) ?
                         memwb_value : exmem_store_data;
  assign mem_result    = exmem_mem_read ? mem_load_value : exmem_alu;

  mem_align u_mem_align (
    .store_addr(exmem_alu), .store_funct3(exmem_funct3), .store_src(mem_store_src),
    .wdata(dcache_wdata), .mbe(dcache_mbe),
    .load_addr(exmem_alu), .load_funct3(exmem_funct3), .load_raw(mem_load_raw),
    .load_value(mem_load_value)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dcache_done <= 1'b0;
    end else if (advance) begin
      dcache_done <= 1'b0;
    end else if ((dcache_read | dcache_write) & dcache_resp) begin
      dcache_done <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (dcache_read && dcache_resp) begin
      held_rdata <= dcache_rdata;
    end
  end

  // PC and pipeline control
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc              <= rv32i_pkg::RESET_PC;
      ifid_instr      <= rv32i_pkg::NOP_INSTR;
      idex_reg_write  <= 1'b0;
      idex_mem_read   <= 1'b0;
      idex_mem_write  <= 1'b0;
      exmem_reg_write <= 1'b0;
      exmem_mem_read  <= 1'b0;
      exmem_mem_write <= 1'b0;
      memwb_reg_write <= 1'b0;
    end else if (advance) begin
      pc              <= pc + 32'd4;
      ifid_instr      <= icache_rdata;
      idex_reg_write  <= id_reg_write;
      idex_mem_read   <= id_mem_read;
      idex_mem_write  <= id_mem_write;
      exmem_reg_write <= idex_reg_write;
      exmem_mem_read  <= idex_mem_read;
      exmem_mem_write <= idex_mem_write;
      memwb_reg_write <= exmem_reg_write;
    end
  end

  // Pipeline payload
  always_ff @(posedge clk) begin
    if (advance) begin
      idex_rs1         <= id_rs1;
      idex_rs2         <= id_rs2;
      idex_rd          <= id_rd;
      idex_imm         <= id_imm;
      idex_rs1_val     <= rf_rdata_a;
      idex_rs2_val     <= rf_rdata_b;
      idex_alu_op      <= id_alu_op;
      idex_src2_imm    <= id_src2_imm;
      idex_funct3      <= id_funct3;
      exmem_rd         <= idex_rd;
      exmem_rs2        <= idex_rs2;
      exmem_alu        <= ex_alu_result;
      exmem_store_data <= ex_store_data;
      exmem_funct3     <= idex_funct3;
      memwb_rd         <= exmem_rd;
      memwb_value      <= mem_result;
    end
  end

endmodule

// File: verilog/decode_ctrl.sv
`timescale 1ns/1ps

module decode_ctrl (
  input  rv32i_pkg::word_t    instr,
  output rv32i_pkg::reg_idx_t rs1,
  output rv32i_pkg::reg_idx_t rs2,
  output rv32i_pkg::reg_idx_t rd,
  output rv32i_pkg::word_t    imm,
  output rv32i_pkg::alu_op_t  alu_op,
  output logic                src2_imm,
  output logic                reg_write,
  output logic                mem_read,
  output logic                mem_write,
  output rv32i_pkg::funct3_t  funct3
);

  rv32i_pkg::word_t i_imm;
  rv32i_pkg::word_t s_imm;
  rv32i_pkg::word_t u_imm;

  // ALU select from funct3, alt picks SUB or SRA
  function automatic rv32i_pkg::alu_op_t alu_decode(rv32i_pkg::funct3_t f3, logic alt);
    case (f3)
      3'b000:  return alt ? rv32i_pkg::ALU_SUB : rv32i_pkg::ALU_ADD;
      3'b001:  return rv32i_pkg::ALU_SLL;
      3'b010:  return rv32i_pkg::ALU_SLT;
      3'b011:  return rv32i_pkg::ALU_SLTU;
      3'b100:  return rv32i_pkg::ALU_XOR;
      3'b101:  return alt ? rv32i_pkg::ALU_SRA : rv32i_pkg::ALU_SRL;
      3'b110:  return rv32i_pkg::ALU_OR;
      default: return rv32i_pkg::ALU_AND;
    endcase
  endfunction

  // Immediate formats
  assign i_imm = {{20{instr[31]}}, instr[31:20]};
  assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign u_imm = {instr[31:12], 12'h000};

  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];

  always_comb begin
    imm       = '0;
    alu_op    = rv32i_pkg::ALU_ADD;
    src2_imm  = 1'b0;
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    case (instr[6:0])
      rv32i_pkg::OP_REG: begin
        reg_write = 1'b1;
        alu_op    = alu_decode(instr[14:12], instr[30]);
      end
      rv32i_pkg::OP_IMM: begin
        reg_write = 1'b1;
        src2_imm  = 1'b1;
        imm       = i_imm;
        // No SUBI, bit 30 only matters for the right shift
        alu_op    = alu_decode(instr[14:12], instr[30] && (instr[14:12] == 3'b101));
      end
      rv32i_pkg::OP_LUI: begin
        reg_write = 1'b1;
        src2_imm  = 1'b1;
        imm       = u_imm;
        alu_op    = rv32i_pkg::ALU_PASS_B;
      end
      rv32i_pkg::OP_LOAD: begin
        reg_write = 1'b1;
        mem_read  = 1'b1;
        src2_imm  = 1'b1;
        imm       = i_imm;
      end
      rv32i_pkg::OP_STORE: begin
        mem_write = 1'b1;
        src2_imm  = 1'b1;
        imm       = s_imm;
      end
      default: begin
        // Anything else drops through as a no-op
      end
    endcase
  end

endmodule

// File: verilog/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  // Instruction in execute
  input  rv32i_pkg::reg_idx_t rs1,
  input  rv32i_pkg::reg_idx_t rs2,
  input  rv32i_pkg::word_t    rs1_val,
  input  rv32i_pkg::word_t    rs2_val,
  input  rv32i_pkg::word_t    imm,
  input  rv32i_pkg::alu_op_t  alu_op,
  input  logic                src2_imm,
  // Memory stage
  input  rv32i_pkg::reg_idx_t mem_rd,
  input  logic                mem_reg_write,
  input  logic                mem_is_load,
  input  rv32i_pkg::word_t    mem_alu,
  input  rv32i_pkg::word_t    mem_rdata,
  // Writeback stage
  input  rv32i_pkg::reg_idx_t wb_rd,
  input  logic                wb_reg_write,
  input  rv32i_pkg::word_t    wb_value,
  // Results
  output rv32i_pkg::word_t    alu_result,
  output rv32i_pkg::word_t    store_data
);

  rv32i_pkg::word_t mem_value;
  logic             mem_hit_a;
  logic             mem_hit_b;
  logic             wb_hit_a;
  logic             wb_hit_b;
  rv32i_pkg::word_t op_a;
  rv32i_pkg::word_t fwd_b;
  rv32i_pkg::word_t op_b;
  logic [4:0]       shamt;

  // Load in memory stage hands over its read data
  assign mem_value = mem_is_load ? mem_rdata : mem_alu;

  // Producers that write x0 never match
  assign mem_hit_a = mem_reg_write && (mem_rd != '0) && (mem_rd == rs1);
  assign mem_hit_b = mem_reg_write && (mem_rd != '0) && (mem_rd == rs2);
  assign wb_hit_a  = wb_reg_write && (wb_rd != '0) && (wb_rd == rs1);
  assign wb_hit_b  = wb_reg_write && (wb_rd != '0) && (wb_rd == rs2);

  // Youngest producer wins
  assign op_a  = mem_hit_a ? mem_value : (wb_hit_a ? wb_value : rs1_val);
  assign fwd_b = mem_hit_b ? mem_value : (wb_hit_b ? wb_value : rs2_val);

  assign op_b       = src2_imm ? imm : fwd_b;
  assign store_data = fwd_b;
  assign shamt      = op_b[4:0];

  always_comb begin
    case (alu_op)
      rv32i_pkg::ALU_ADD:    alu_result = op_a + op_b;
      rv32i_pkg::ALU_SUB:    alu_result = op_a - op_b;
      rv32i_pkg::ALU_SLL:    alu_result = op_a << shamt;
      rv32i_pkg::ALU_SLT:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      rv32i_pkg::ALU_SLTU:   alu_result = {31'b0, op_a < op_b};
      rv32i_pkg::ALU_XOR:    alu_result = op_a ^ op_b;
      rv32i_pkg::ALU_SRL:    alu_result = op_a >> shamt;
      rv32i_pkg::ALU_SRA:    alu_result = $unsigned($signed(op_a) >>> shamt);
      rv32i_pkg::ALU_OR:     alu_result = op_a | op_b;
      rv32i_pkg::ALU_AND:    alu_result = op_a & op_b;
      rv32i_pkg::ALU_PASS_B: alu_result = op_b;
      default:               alu_result = '0;
    endcase
  end

endmodule

// File: verilog/mem_align.sv
`timescale 1ns/1ps

module mem_align (
  input  rv32i_pkg::word_t   store_addr,
  input  rv32i_pkg::funct3_t store_funct3,
  input  rv32i_pkg::word_t   store_src,
  output rv32i_pkg::word_t   wdata,
  output rv32i_pkg::mbe_t    mbe,
  input  rv32i_pkg::word_t   load_addr,
  input  rv32i_pkg::funct3_t load_funct3,
  input  rv32i_pkg::word_t   load_raw,
  output rv32i_pkg::word_t   load_value
);

  logic [1:0]  store_off;
  logic [1:0]  load_off;
  logic [7:0]  byte_val;
  logic [15:0] half_val;
  logic        half_ok;

  assign store_off = store_addr[1:0];
  assign load_off  = load_addr[1:0];

  // Store lane placement
  always_comb begin
    wdata = '0;
    mbe   = '0;
    case (store_funct3)
      rv32i_pkg::F3_B: begin
        wdata = store_src << {store_off, 3'b000};
        mbe   = 4'b0001 << store_off;
      end
      rv32i_pkg::F3_H: begin
        // Upper lane falls off at offset 3
        wdata = store_src << {store_off, 3'b000};
        mbe   = 4'b0011 << store_off;
      end
      rv32i_pkg::F3_W: begin
        wdata = store_src;
        mbe   = 4'b1111;
      end
      default: begin
      end
    endcase
  end

  // Load lane extraction
  assign byte_val = load_raw[{load_off, 3'b000} +: 8];
  assign half_val = load_off[1] ? load_raw[31:16] : load_raw[15:0];
  assign half_ok  = ~load_off[0];

  always_comb begin
    case (load_funct3)
      rv32i_pkg::F3_B:  load_value = {{24{byte_val[7]}}, byte_val};
      rv32i_pkg::F3_BU: load_value = {24'b0, byte_val};
      rv32i_pkg::F3_H:  load_value = half_ok ? {{16{half_val[15]}}, half_val} : '0;
      rv32i_pkg::F3_HU: load_value = half_ok ? {16'b0, half_val} : '0;
      rv32i_pkg::F3_W:  load_value = load_raw;
      default:          load_value = '0;
    endcase
  end

endmodule

// File: verilog/regfile.sv
`timescale 1ns/1ps

module regfile (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                we,
  input  rv32i_pkg::reg_idx_t waddr,
  input  rv32i_pkg::word_t    wdata,
  input  rv32i_pkg::reg_idx_t raddr_a,
  input  rv32i_pkg::reg_idx_t raddr_b,
  output rv32i_pkg::word_t    rdata_a,
  output rv32i_pkg::word_t    rdata_b
);

  // x1 to x31, x0 has no storage
  rv32i_pkg::word_t regs [1:31];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // Same-cycle write shows up on the read ports
  assign rdata_a = (raddr_a == '0) ? '0 :
                   (we && (waddr == raddr_a)) ? wdata : regs[raddr_a];
  assign rdata_b = (raddr_b == '0) ? '0 :
                   (we && (waddr == raddr_b)) ? wdata : regs[raddr_b];

endmodule

// File: verilog/rv32i_pkg.sv
package rv32i_pkg;

  // Data path width
  localparam int XLEN = 32;

  // Words, register indices, byte lanes
  typedef logic [XLEN-1:0]   word_t;
  typedef logic [4:0]        reg_idx_t;
  typedef logic [XLEN/8-1:0] mbe_t;
  typedef logic [2:0]        funct3_t;

  // ALU operation select
  typedef logic [3:0] alu_op_t;

  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_SLL    = 4'd2;
  localparam alu_op_t ALU_SLT    = 4'd3;
  localparam alu_op_t ALU_SLTU   = 4'd4;
  localparam alu_op_t ALU_XOR    = 4'd5;
  localparam alu_op_t ALU_SRL    = 4'd6;
  localparam alu_op_t ALU_SRA    = 4'd7;
  localparam alu_op_t ALU_OR     = 4'd8;
  localparam alu_op_t ALU_AND    = 4'd9;
  // Second operand straight through, used by LUI
  localparam alu_op_t ALU_PASS_B = 4'd10;

  // Major opcodes of the supported subset
  localparam logic [6:0] OP_REG   = 7'b0110011;
  localparam logic [6:0] OP_IMM   = 7'b0010011;
  localparam logic [6:0] OP_LUI   = 7'b0110111;
  localparam logic [6:0] OP_LOAD  = 7'b0000011;
  localparam logic [6:0] OP_STORE = 7'b0100011;

  // Access size in funct3 of loads and stores
  localparam funct3_t F3_B  = 3'b000;
  localparam funct3_t F3_H  = 3'b001;
  localparam funct3_t F3_W  = 3'b010;
  localparam funct3_t F3_BU = 3'b100;
  localparam funct3_t F3_HU = 3'b101;

  // addi x0, x0, 0
  localparam word_t NOP_INSTR = 32'h0000_0013;

  // First fetch address out of reset
  localparam word_t RESET_PC = 32'h0000_0000;

endpackage
